/* Makefile */
# Verilator build and run for the tank game screen

VERILATOR ?= verilator
TOP       ?= tankGameTb
FILE_LIST ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= Simulation completed successfully

SOURCES := $(filter %.sv %.v,$(shell cat $(FILE_LIST)))
HEADERS := $(wildcard include/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, a header or the file list changes
$(BIN): $(FILE_LIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tankGameTb.sv */
`timescale 1ns/10ps
`include "tankGame_macros.svh"

module tankGameTb;

	logic                     Master_Clock_In;
	logic                     arstN;
	logic                     displayEnable;
	logic [`COORD_WIDTH-1:0]  pixelX;
	logic [`COORD_WIDTH-1:0]  pixelY;
	logic                     up;
	logic                     down;
	logic                     left;
	logic                     right;
	logic [`COLOUR_WIDTH-1:0] red;
	logic [`COLOUR_WIDTH-1:0] green;
	logic [`COLOUR_WIDTH-1:0] blue;
	logic [`COIN_WIDTH-1:0]   coinCount;
	logic [`COORD_WIDTH-1:0]  tankX;
	logic [`COORD_WIDTH-1:0]  tankY;

	// Expected tank, score and map
	int expX;
	int expY;
	int expCoins;
	tankGamePkg::mapRowT benchMap [`MAP_ROWS];
	int valueErrors;
	int timeoutErrors;

	tankGameTop u_tankGameTop
	(
		.Master_Clock_In (Master_Clock_In),
		.arstN           (arstN),
		.displayEnable   (displayEnable),
		.pixelX          (pixelX),
		.pixelY          (pixelY),
		.up              (up),
		.down            (down),
		.left            (left),
		.right           (right),
		.red             (red),
		.green           (green),
		.blue            (blue),
		.coinCount       (coinCount),
		.tankX           (tankX),
		.tankY           (tankY)
	);

	// 4 ns clock
	initial
	begin
		Master_Clock_In = 1'b0;
		forever #2 Master_Clock_In = ~Master_Clock_In;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Tile code under a pixel with indexes folded into the map
	function automatic logic [3:0] codeAt(input int x, input int y);
		return benchMap[(y >> `TILE_SHIFT) % `MAP_ROWS][(x >> `TILE_SHIFT) % `MAP_COLS];
	endfunction

	function automatic tankGamePkg::colourT expectedColour(input logic en, input int x,
		input int y);
		if (!en)
			return tankGamePkg::blankColour;
		if (x > `SCREEN_WIDTH || y > `SCREEN_HEIGHT)
			return tankGamePkg::offScreenColour;
		// Inclusive box
		if (x >= expX && x <= expX + `TANK_WIDTH && y >= expY && y <= expY + `TANK_WIDTH)
			return tankGamePkg::tankColour;
		return tankGamePkg::tileColour(tankGamePkg::tileCodeT'(codeAt(x, y)));
	endfunction

	// Next tank state for one frame from the current buttons
	task automatic predictFrame();
		int  x;
		int  y;
		int  cx [4];
		int  cy [4];
		bit  wall [4];
		bit  coin [4];
		bit  coinFound;
		x = expX;
		y = expY;
		if (x == 0)
			x = `SCREEN_WIDTH - `TANK_WIDTH - 1;
		else if (x == `SCREEN_WIDTH - `TANK_WIDTH)
			x = 1;
		if (y == 0)
			y = `SCREEN_HEIGHT - `TANK_WIDTH - 1;
		else if (y == `SCREEN_HEIGHT - `TANK_WIDTH)
			y = 1;
		// Corners TL, TR, BL, BR
		cx = '{x, x + `TANK_WIDTH, x, x + `TANK_WIDTH};
		cy = '{y, y, y + `TANK_WIDTH, y + `TANK_WIDTH};
		for (int i = 0; i < 4; i++)
		begin
			wall[i] = (codeAt(cx[i], cy[i]) == 4'd1) || (codeAt(cx[i], cy[i]) == 4'd2);
			coin[i] = (codeAt(cx[i], cy[i]) == 4'd3);
		end
		coinFound = 1'b0;
		if (wall[2] && wall[3])
			y--;
		else if (wall[0] && wall[2])
			x++;
		else if (wall[0] && wall[1])
			y++;
		else if (wall[1] && wall[3])
			x--;
		else if (wall[0])
		begin
			x++;
			y++;
		end
		else if (wall[1])
		begin
			x--;
			y++;
		end
		else if (wall[2])
		begin
			x++;
			y--;
		end
		else if (wall[3])
		begin
			x--;
			y--;
		end
		else if (coin[0] || coin[1] || coin[2] || coin[3])
		begin
			// First coin corner becomes floor
			for (int i = 0; i < 4; i++)
			begin
				if (coin[i] && !coinFound)
				begin
					benchMap[(cy[i] >> `TILE_SHIFT) % `MAP_ROWS]
						[(cx[i] >> `TILE_SHIFT) % `MAP_COLS] = 4'd0;
					coinFound = 1'b1;
				end
			end
			expCoins = (expCoins + 1) % 256;
		end
		else if (up)
			y--;
		else if (right)
			x++;
		else if (down)
			y++;
		else if (left)
			x--;
		expX = x;
		expY = y;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus and checks
	//////////////////////////////////////////////////////////////////////

	task automatic checkValue(input string testName, input int expected, input int actual);
		assert (actual == expected)
		else
		begin
			valueErrors++;
			$display("** Error %s: expected %0h, actual %0h", testName, expected, actual);
		end
	endtask

	// One pixel through the two-stage pipe
	task automatic checkPixel(input string testName, input logic en, input int x, input int y);
		tankGamePkg::colourT expected;
		expected = expectedColour(en, x, y);
		@(negedge Master_Clock_In);
		displayEnable = en;
		pixelX = `COORD_WIDTH'(x);
		pixelY = `COORD_WIDTH'(y);
		@(negedge Master_Clock_In);
		@(negedge Master_Clock_In);
		checkValue(testName, int'(expected), int'({red, green, blue}));
	endtask

	// Frame event for one cycle then a tank compare after the strobe edge
	task automatic fireFrame(input string testName);
		int waited;
		predictFrame();
		@(negedge Master_Clock_In);
		displayEnable = 1'b1;
		pixelX = `COORD_WIDTH'(`SCREEN_WIDTH);
		pixelY = `COORD_WIDTH'(`SCREEN_HEIGHT);
		@(negedge Master_Clock_In);
		pixelX = '0;
		pixelY = '0;
		waited = 0;
		while (!u_tankGameTop.frameStrobe && waited < 10)
		begin
			@(negedge Master_Clock_In);
			waited++;
		end
		if (!u_tankGameTop.frameStrobe)
		begin
			timeoutErrors++;
			$display("Timeout: no frame strobe arrived during %s", testName);
		end
		else
		begin
			@(negedge Master_Clock_In);
		end
		checkValue({testName, " x"}, expX, int'(tankX));
		checkValue({testName, " y"}, expY, int'(tankY));
		checkValue({testName, " coins"}, expCoins, int'(coinCount));
	endtask

	initial
	begin
		int x;
		int y;
		int prevX;
		int prevY;
		int checkerFails;
		void'($urandom(32'h6134bebe));
		valueErrors = 0;
		timeoutErrors = 0;
		arstN = 1'b0;
		displayEnable = 1'b0;
		pixelX = '0;
		pixelY = '0;
		up = 1'b0;
		down = 1'b0;
		left = 1'b0;
		right = 1'b0;
		for (int r = 0; r < `MAP_ROWS; r++)
			benchMap[r] = tankGamePkg::mapInit[r];
		expX = `TANK_START;
		expY = `TANK_START;
		expCoins = 0;
		repeat (2) @(negedge Master_Clock_In);
		arstN = 1'b1;

		// Reset state
		checkValue("reset colour", 0, int'({red, green, blue}));
		checkValue("reset coins", 0, int'(coinCount));
		checkValue("reset tankX", `TANK_START, int'(tankX));
		checkValue("reset tankY", `TANK_START, int'(tankY));

		// Blanking and off-screen
		for (int n = 0; n < 20; n++)
		begin
			checkPixel("blank", 1'b0, $urandom_range(0, 1023), $urandom_range(0, 1023));
			if ($urandom_range(0, 1) == 1)
				checkPixel("off screen", 1'b1, $urandom_range(641, 1023),
					$urandom_range(0, 1023));
			else
				checkPixel("off screen", 1'b1, $urandom_range(0, 1023),
					$urandom_range(481, 1023));
		end

		// Map tiles and the tank body away from the frame point
		for (int n = 0; n < 30; n++)
		begin
			x = $urandom_range(0, `SCREEN_WIDTH);
			y = $urandom_range(0, `SCREEN_HEIGHT);
			if (x == `SCREEN_WIDTH && y == `SCREEN_HEIGHT)
				x = 0;
			checkPixel("tile colour", 1'b1, x, y);
			checkPixel("tank colour", 1'b1, expX + $urandom_range(0, 25),
				expY + $urandom_range(0, 25));
		end

		// Right across floor up to x of 20
		right = 1'b1;
		repeat (15) fireFrame("move right");
		right = 1'b0;
		checkValue("move right end", 20, int'(tankX));

		// Down into the wall at row 1, column 1
		down = 1'b1;
		for (int n = 0; n < 8; n++)
		begin
			prevX = expX;
			prevY = expY;
			fireFrame("push back");
			assert (tankY <= 7)
			else
			begin
				valueErrors++;
				$display("** Error push back limit: expected at most 7, actual %0d", tankY);
			end
			if (prevY == 7)
			begin
				checkValue("push back x", prevX - 1, int'(tankX));
				checkValue("push back y", 6, int'(tankY));
			end
		end
		down = 1'b0;

		// Up along row 0 and then left to the edge
		up = 1'b1;
		repeat (6) fireFrame("move up");
		up = 1'b0;
		left = 1'b1;
		for (int n = 0; n < 40 && expX != 0; n++)
			fireFrame("move left");
		left = 1'b0;
		checkValue("left edge", 0, int'(tankX));

		// Wrap both ways
		fireFrame("wrap left");
		checkValue("wrap left", 614, int'(tankX));
		right = 1'b1;
		fireFrame("wrap right");
		fireFrame("wrap right");
		checkValue("wrap right", 2, int'(tankX));
		for (int n = 0; n < 80 && expX != 66; n++)
			fireFrame("move right");
		right = 1'b0;

		// Down onto the coin at row 1, column 2
		down = 1'b1;
		repeat (8) fireFrame("coin");
		down = 1'b0;
		checkValue("coin total", 1, int'(coinCount));
		checkPixel("cleared coin", 1'b1, 94, 50);

		// Map after the clear
		for (int n = 0; n < 10; n++)
		begin
			x = $urandom_range(0, `SCREEN_WIDTH - 1);
			y = $urandom_range(0, `SCREEN_HEIGHT);
			checkPixel("tile after clear", 1'b1, x, y);
		end

		checkerFails = u_tankGameTop.u_tankGameChecker.failCount;
		$display("Errors: %0d value, %0d timeout, %0d assertion",
			valueErrors, timeoutErrors, checkerFails);
		if (valueErrors == 0 && timeoutErrors == 0 && checkerFails == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* bench/tankGame_checker.sv */
`timescale 1ns/10ps
`include "tankGame_macros.svh"

// Cycle rules watched inside the top level
module tankGameChecker
(
	input logic                     Master_Clock_In,
	input logic                     arstN,
	input logic                     frameStrobe,
	input logic                     blank,
	input logic                     clearEnable,
	input logic [`COIN_WIDTH-1:0]   coinCount,
	input logic [`COORD_WIDTH-1:0]  tankX,
	input logic [`COORD_WIDTH-1:0]  tankY,
	input logic [`COLOUR_WIDTH-1:0] red,
	input logic [`COLOUR_WIDTH-1:0] green,
	input logic [`COLOUR_WIDTH-1:0] blue
);

	// Failed assertions so far
	int failCount = 0;

	//////////////////////////////////////////////////////////////////////
	// Frame strobe and tank state
	//////////////////////////////////////////////////////////////////////

	// One strobe cycle per frame event
	strobeOneCycle: assert property (@(posedge Master_Clock_In) disable iff (!arstN)
		frameStrobe |=> !frameStrobe)
	else
	begin
		failCount++;
		$error("frame strobe stayed high for more than one cycle");
	end

	// Score frozen between frames
	coinHeld: assert property (@(posedge Master_Clock_In) disable iff (!arstN)
		!frameStrobe |=> $stable(coinCount))
	else
	begin
		failCount++;
		$error("coin count changed without a frame strobe");
	end

	// Tank frozen between frames
	tankHeld: assert property (@(posedge Master_Clock_In) disable iff (!arstN)
		!frameStrobe |=> ($stable(tankX) && $stable(tankY)))
	else
	begin
		failCount++;
		$error("tank moved without a frame strobe");
	end

	// At most one coin per frame
	coinStep: assert property (@(posedge Master_Clock_In) disable iff (!arstN)
		frameStrobe |=> ((coinCount == $past(coinCount))
			|| (coinCount == $past(coinCount) + 8'd1)))
	else
	begin
		failCount++;
		$error("coin count jumped by more than one in a frame");
	end

	// Every map clear scores one coin
	clearScores: assert property (@(posedge Master_Clock_In) disable iff (!arstN)
		clearEnable |=> (coinCount == $past(coinCount) + 8'd1))
	else
	begin
		failCount++;
		$error("map clear did not raise the coin count by one");
	end

	// Blanked pixel comes out black
	blankBlack: assert property (@(posedge Master_Clock_In) disable iff (!arstN)
		blank |=> ({red, green, blue} == 12'h000))
	else
	begin
		failCount++;
		$error("blanked pixel was not black");
	end

endmodule

bind tankGameTop tankGameChecker u_tankGameChecker
(
	.Master_Clock_In (Master_Clock_In),
	.arstN           (arstN),
	.frameStrobe     (frameStrobe),
	.blank           (blank),
	.clearEnable     (clearEnable),
	.coinCount       (coinCount),
	.tankX           (tankX),
	.tankY           (tankY),
	.red             (red),
	.green           (green),
	.blue            (blue)
);

/* build.f */
+incdir+include
design/tankGamePkg.sv
design/tileMap.sv
design/pixelDecode.sv
design/tankMotion.sv
design/pixelColour.sv
design/tankGameTop.sv
bench/tankGame_checker.sv
bench/tankGameTb.sv

/* design/pixelColour.sv */
`timescale 1ns/10ps
`include "tankGame_macros.svh"

// Result stage, forms the output colour
module pixelColour
(
	input  logic                       Master_Clock_In,
	input  logic                       arstN,
	input  logic [`COORD_WIDTH-1:0]    pixelXReg,
	input  logic [`COORD_WIDTH-1:0]    pixelYReg,
	input  logic                       blank,
	input  logic                       onScreen,
	input  tankGamePkg::tileCodeT      pixelCode,
	input  logic [`COORD_WIDTH-1:0]    tankX,
	input  logic [`COORD_WIDTH-1:0]    tankY,
	output logic [`COLOUR_WIDTH-1:0]   red,
	output logic [`COLOUR_WIDTH-1:0]   green,
	output logic [`COLOUR_WIDTH-1:0]   blue
);

	logic                inTank;
	tankGamePkg::colourT nextColour;

	// Inclusive tank box, sums kept wide so nothing wraps
	assign inTank = (pixelXReg >= tankX)
		&& (pixelXReg <= tankX + `TANK_WIDTH)
		&& (pixelYReg >= tankY)
		&& (pixelYReg <= tankY + `TANK_WIDTH);

	//////////////////////////////////////////////////////////////////////
	// Colour priority
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// Blanking beats everything
		if (blank)
			nextColour = tankGamePkg::blankColour;
		else if (!onScreen)
			nextColour = tankGamePkg::offScreenColour;
		// Tank drawn over the map
		else if (inTank)
			nextColour = tankGamePkg::tankColour;
		else
			nextColour = tankGamePkg::tileColour(pixelCode);
	end

	// Output register, second pipe stage
	always_ff @(posedge Master_Clock_In or negedge arstN)
	begin
		if (!arstN)
		begin
			red   <= '0;
			green <= '0;
			blue  <= '0;
		end
		else
		begin
			red   <= nextColour.red;
			green <= nextColour.green;
			blue  <= nextColour.blue;
		end
	end

endmodule

/* design/pixelDecode.sv */
`timescale 1ns/10ps
`include "tankGame_macros.svh"

// Decode stage of the pixel pipe
module pixelDecode
(
	input  logic                      Master_Clock_In,
	input  logic                      arstN,
	input  logic                      displayEnable,
	input  logic [`COORD_WIDTH-1:0]   pixelX,
	input  logic [`COORD_WIDTH-1:0]   pixelY,
	output logic [`COORD_WIDTH-1:0]   pixelXReg,
	output logic [`COORD_WIDTH-1:0]   pixelYReg,
	output logic [`COL_WIDTH-1:0]     pixelCol,
	output logic [`ROW_WIDTH-1:0]     pixelRow,
	output logic                      blank,
	output logic                      onScreen,
	output logic                      frameStrobe
);

	logic frameEvent;

	// Last visible pixel of the frame while display is on
	assign frameEvent = displayEnable
		&& (pixelX == `COORD_WIDTH'(`SCREEN_WIDTH))
		&& (pixelY == `COORD_WIDTH'(`SCREEN_HEIGHT));

	// Raster position, one cycle late
	always_ff @(posedge Master_Clock_In)
	begin
		pixelXReg <= pixelX;
		pixelYReg <= pixelY;
	end

	// Flags and frame strobe
	always_ff @(posedge Master_Clock_In or negedge arstN)
	begin
		if (!arstN)
		begin
			blank       <= 1'b1;
			onScreen    <= 1'b0;
			frameStrobe <= 1'b0;
		end
		else
		begin
			blank       <= !displayEnable;
			onScreen    <= (pixelX <= `COORD_WIDTH'(`SCREEN_WIDTH))
				&& (pixelY <= `COORD_WIDTH'(`SCREEN_HEIGHT));
			// High for a single cycle per frame
			frameStrobe <= frameEvent;
		end
	end

	// Tile under the pixel, folded into the map size
	assign pixelCol = `COL_WIDTH'((pixelXReg >> `TILE_SHIFT) % `MAP_COLS);
	assign pixelRow = `ROW_WIDTH'((pixelYReg >> `TILE_SHIFT) % `MAP_ROWS);

endmodule

/* design/tankGamePkg.sv */
`include "tankGame_macros.svh"

package tankGamePkg;

	// Tile codes held in the map
	// Codes 4 to 7 all count as hazard
	typedef enum logic [`CODE_WIDTH-1:0]
	{
		tileFloor    = 4'd0,
		tileHardWall = 4'd1,
		tileWall     = 4'd2,
		tileCoin     = 4'd3,
		tileHazard   = 4'd4
	} tileCodeT;

	// 4 bits each of red, green, blue
	typedef struct packed
	{
		logic [`COLOUR_WIDTH-1:0] red;
		logic [`COLOUR_WIDTH-1:0] green;
		logic [`COLOUR_WIDTH-1:0] blue;
	} colourT;

	// One map row, column 0 in the leftmost nibble
	typedef logic [0:`MAP_COLS-1][`CODE_WIDTH-1:0] mapRowT;

	//////////////////////////////////////////////////////////////////////
	// Reset layout
	//////////////////////////////////////////////////////////////////////

	// Floor border, walls and coins inside
	localparam mapRowT mapInit [`MAP_ROWS] = '{
		80'h0000_0000_0000_0000_0000,
		80'h0232_3223_2332_3223_2320,
		80'h0332_3333_2332_3333_2330,
		80'h0222_2223_2332_3222_2220,
		80'h0332_3333_2332_3333_2330,
		80'h0232_3223_2222_3223_2330,
		80'h0333_3333_3333_3333_3330,
		80'h0222_2232_2222_2322_2220,
		80'h0333_3333_3333_3333_3330,
		80'h0232_3223_2222_3223_2320,
		80'h0332_3333_2332_3333_2330,
		80'h0222_2223_2332_3222_2220,
		80'h0332_3333_2332_3333_2330,
		80'h0232_3223_2332_3223_2320,
		80'h0000_0000_0000_0000_0000
	};

	// Fixed colours
	localparam colourT tankColour      = 12'h2A2;
	localparam colourT offScreenColour = 12'h222;
	localparam colourT blankColour     = 12'h000;

	// Flat colour per tile code
	function automatic colourT tileColour(input tileCodeT code);
		colourT result;
		case (code)
			tileFloor:    result = 12'hEEE;
			tileHardWall: result = 12'h964;
			tileWall:     result = 12'hA52;
			tileCoin:     result = 12'hFD0;
			tileHazard, 4'd5, 4'd6, 4'd7:
				result = 12'hF44;
			// Unknown codes show grey
			default:      result = 12'h888;
		endcase
		return result;
	endfunction

endpackage

/* design/tankGameTop.sv */
`timescale 1ns/10ps
`include "tankGame_macros.svh"

// Tank game screen, decode then execute then colour
module tankGameTop
(
	input  logic                       Master_Clock_In,
	input  logic                       arstN,
	input  logic                       displayEnable,
	input  logic [`COORD_WIDTH-1:0]    pixelX,
	input  logic [`COORD_WIDTH-1:0]    pixelY,
	input  logic                       up,
	input  logic                       down,
	input  logic                       left,
	input  logic                       right,
	output logic [`COLOUR_WIDTH-1:0]   red,
	output logic [`COLOUR_WIDTH-1:0]   green,
	output logic [`COLOUR_WIDTH-1:0]   blue,
	output logic [`COIN_WIDTH-1:0]     coinCount,
	output logic [`COORD_WIDTH-1:0]    tankX,
	output logic [`COORD_WIDTH-1:0]    tankY
);

	// Decode stage outputs
	logic [`COORD_WIDTH-1:0] pixelXReg;
	logic [`COORD_WIDTH-1:0] pixelYReg;
	logic [`COL_WIDTH-1:0]   pixelCol;
	logic [`ROW_WIDTH-1:0]   pixelRow;
	logic                    blank;
	logic                    onScreen;
	logic                    frameStrobe;

	// Map traffic
	tankGamePkg::tileCodeT   pixelCode;
	tankGamePkg::tileCodeT   cornerCode [4];
	logic [`COL_WIDTH-1:0]   cornerCol [4];
	logic [`ROW_WIDTH-1:0]   cornerRow [4];
	logic                    clearEnable;
	logic [`COL_WIDTH-1:0]   clearCol;
	logic [`ROW_WIDTH-1:0]   clearRow;

	pixelDecode u_pixelDecode
	(
		.Master_Clock_In (Master_Clock_In),
		.arstN           (arstN),
		.displayEnable   (displayEnable),
		.pixelX          (pixelX),
		.pixelY          (pixelY),
		.pixelXReg       (pixelXReg),
		.pixelYReg       (pixelYReg),
		.pixelCol        (pixelCol),
		.pixelRow        (pixelRow),
		.blank           (blank),
		.onScreen        (onScreen),
		.frameStrobe     (frameStrobe)
	);

	tileMap u_tileMap
	(
		.Master_Clock_In (Master_Clock_In),
		.arstN           (arstN),
		.pixelCol        (pixelCol),
		.pixelRow        (pixelRow),
		.cornerCol       (cornerCol),
		.cornerRow       (cornerRow),
		.clearEnable     (clearEnable),
		.clearCol        (clearCol),
		.clearRow        (clearRow),
		.pixelCode       (pixelCode),
		.cornerCode      (cornerCode)
	);

	tankMotion u_tankMotion
	(
		.Master_Clock_In (Master_Clock_In),
		.arstN           (arstN),
		.frameStrobe     (frameStrobe),
		.up              (up),
		.down            (down),
		.left            (left),
		.right           (right),
		.cornerCode      (cornerCode),
		.cornerCol       (cornerCol),
		.cornerRow       (cornerRow),
		.clearEnable     (clearEnable),
		.clearCol        (clearCol),
		.clearRow        (clearRow),
		.tankX           (tankX),
		.tankY           (tankY),
		.coinCount       (coinCount)
	);

	pixelColour u_pixelColour
	(
		.Master_Clock_In (Master_Clock_In),
		.arstN           (arstN),
		.pixelXReg       (pixelXReg),
		.pixelYReg       (pixelYReg),
		.blank           (blank),
		.onScreen        (onScreen),
		.pixelCode       (pixelCode),
		.tankX           (tankX),
		.tankY           (tankY),
		.red             (red),
		.green           (green),
		.blue            (blue)
	);

endmodule

/* design/tankMotion.sv */
`timescale 1ns/10ps
`include "tankGame_macros.svh"

// Execute stage, owns the tank and the score
module tankMotion
(
	input  logic                      Master_Clock_In,
	input  logic                      arstN,
	input  logic                      frameStrobe,
	input  logic                      up,
	input  logic                      down,
	input  logic                      left,
	input  logic                      right,
	input  tankGamePkg::tileCodeT     cornerCode [4],
	output logic [`COL_WIDTH-1:0]     cornerCol [4],
	output logic [`ROW_WIDTH-1:0]     cornerRow [4],
	output logic                      clearEnable,
	output logic [`COL_WIDTH-1:0]     clearCol,
	output logic [`ROW_WIDTH-1:0]     clearRow,
	output logic [`COORD_WIDTH-1:0]   tankX,
	output logic [`COORD_WIDTH-1:0]   tankY,
	output logic [`COIN_WIDTH-1:0]    coinCount
);

	// Wrap targets and trigger points per axis
	localparam logic [`COORD_WIDTH-1:0] WrapToX = `COORD_WIDTH'(`SCREEN_WIDTH - `TANK_WIDTH - 1);
	localparam logic [`COORD_WIDTH-1:0] EdgeX   = `COORD_WIDTH'(`SCREEN_WIDTH - `TANK_WIDTH);
	localparam logic [`COORD_WIDTH-1:0] WrapToY = `COORD_WIDTH'(`SCREEN_HEIGHT - `TANK_WIDTH - 1);
	localparam logic [`COORD_WIDTH-1:0] EdgeY   = `COORD_WIDTH'(`SCREEN_HEIGHT - `TANK_WIDTH);
	localparam logic [`COORD_WIDTH-1:0] Step    = `COORD_WIDTH'(1);

	logic [`COORD_WIDTH-1:0] wrapX;
	logic [`COORD_WIDTH-1:0] wrapY;
	logic [`COORD_WIDTH-1:0] rightX;
	logic [`COORD_WIDTH-1:0] bottomY;
	logic [`COORD_WIDTH-1:0] nextX;
	logic [`COORD_WIDTH-1:0] nextY;
	logic [`COIN_WIDTH-1:0]  nextCoin;
	logic [3:0]              isWall;
	logic [3:0]              isCoin;
	logic                    coinHit;

	//////////////////////////////////////////////////////////////////////
	// Wrap and corner lookup
	//////////////////////////////////////////////////////////////////////

	// Left or top edge jumps to the far side, far edge jumps back to 1
	always_comb
	begin
		if (tankX == '0)
			wrapX = WrapToX;
		else if (tankX == EdgeX)
			wrapX = Step;
		else
			wrapX = tankX;
		if (tankY == '0)
			wrapY = WrapToY;
		else if (tankY == EdgeY)
			wrapY = Step;
		else
			wrapY = tankY;
	end

	// Far corners of the inclusive box
	assign rightX  = wrapX + `COORD_WIDTH'(`TANK_WIDTH);
	assign bottomY = wrapY + `COORD_WIDTH'(`TANK_WIDTH);

	// Corner tiles from the wrapped position
	always_comb
	begin
		cornerCol[0] = `COL_WIDTH'((wrapX >> `TILE_SHIFT) % `MAP_COLS);
		cornerCol[1] = `COL_WIDTH'((rightX >> `TILE_SHIFT) % `MAP_COLS);
		cornerCol[2] = cornerCol[0];
		cornerCol[3] = cornerCol[1];
		cornerRow[0] = `ROW_WIDTH'((wrapY >> `TILE_SHIFT) % `MAP_ROWS);
		cornerRow[1] = cornerRow[0];
		cornerRow[2] = `ROW_WIDTH'((bottomY >> `TILE_SHIFT) % `MAP_ROWS);
		cornerRow[3] = cornerRow[2];
	end

	// Classify what each corner sits on
	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			isWall[i] = (cornerCode[i] == tankGamePkg::tileHardWall)
				|| (cornerCode[i] == tankGamePkg::tileWall);
			isCoin[i] = (cornerCode[i] == tankGamePkg::tileCoin);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Move decision
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		nextX    = wrapX;
		nextY    = wrapY;
		nextCoin = coinCount;
		coinHit  = 1'b0;
		clearCol = cornerCol[0];
		clearRow = cornerRow[0];
		// Whole edges first
		if (isWall[2] && isWall[3])
			nextY = wrapY - Step;
		else if (isWall[0] && isWall[2])
			nextX = wrapX + Step;
		else if (isWall[0] && isWall[1])
			nextY = wrapY + Step;
		else if (isWall[1] && isWall[3])
			nextX = wrapX - Step;
		// Single corners push diagonally away
		else if (isWall[0])
		begin
			nextX = wrapX + Step;
			nextY = wrapY + Step;
		end
		else if (isWall[1])
		begin
			nextX = wrapX - Step;
			nextY = wrapY + Step;
		end
		else if (isWall[2])
		begin
			nextX = wrapX + Step;
			nextY = wrapY - Step;
		end
		else if (isWall[3])
		begin
			nextX = wrapX - Step;
			nextY = wrapY - Step;
		end
		// Collect one coin per frame
		else if (|isCoin)
		begin
			coinHit  = 1'b1;
			nextCoin = coinCount + `COIN_WIDTH'(1);
			// Lowest corner number wins
			for (int i = 3; i >= 0; i--)
			begin
				if (isCoin[i])
				begin
					clearCol = cornerCol[i];
					clearRow = cornerRow[i];
				end
			end
		end
		// Buttons last, first pressed wins
		else if (up)
			nextY = wrapY - Step;
		else if (right)
			nextX = wrapX + Step;
		else if (down)
			nextY = wrapY + Step;
		else if (left)
			nextX = wrapX - Step;
	end

	// Map clear lands on the same edge as the move
	assign clearEnable = frameStrobe && coinHit;

	// Tank state advances once per frame
	always_ff @(posedge Master_Clock_In or negedge arstN)
	begin
		if (!arstN)
		begin
			tankX     <= `COORD_WIDTH'(`TANK_START);
			tankY     <= `COORD_WIDTH'(`TANK_START);
			coinCount <= '0;
		end
		else if (frameStrobe)
		begin
			tankX     <= nextX;
			tankY     <= nextY;
			coinCount <= nextCoin;
		end
	end

endmodule

/* design/tileMap.sv */
`timescale 1ns/10ps
`include "tankGame_macros.svh"

// Tile code store for the 20 by 15 playfield
module tileMap
(
	input  logic                     Master_Clock_In,
	input  logic                     arstN,
	// Pixel read port
	input  logic [`COL_WIDTH-1:0]    pixelCol,
	input  logic [`ROW_WIDTH-1:0]    pixelRow,
	// Corner read ports
	// Order is top-left, top-right, bottom-left, bottom-right
	input  logic [`COL_WIDTH-1:0]    cornerCol [4],
	input  logic [`ROW_WIDTH-1:0]    cornerRow [4],
	// Clear port
	input  logic                     clearEnable,
	input  logic [`COL_WIDTH-1:0]    clearCol,
	input  logic [`ROW_WIDTH-1:0]    clearRow,
	output tankGamePkg::tileCodeT    pixelCode,
	output tankGamePkg::tileCodeT    cornerCode [4]
);

	// One packed row of nibbles per map row
	tankGamePkg::mapRowT mapRows [`MAP_ROWS];

	//////////////////////////////////////////////////////////////////////
	// Write side
	//////////////////////////////////////////////////////////////////////

	// Layout reloads on reset
	// A clear turns one tile into floor
	always_ff @(posedge Master_Clock_In or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int r = 0; r < `MAP_ROWS; r++)
			begin
				mapRows[r] <= tankGamePkg::mapInit[r];
			end
		end
		else if (clearEnable)
		begin
			mapRows[clearRow][clearCol] <= tankGamePkg::tileFloor;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read side
	//////////////////////////////////////////////////////////////////////

	// Indexes arrive already folded into the map size
	// Pixel lookup for the colour stage
	always_comb
	begin
		pixelCode = tankGamePkg::tileCodeT'(mapRows[pixelRow][pixelCol]);
	end

	// Four corner lookups for the tank
	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			cornerCode[i] = tankGamePkg::tileCodeT'(mapRows[cornerRow[i]][cornerCol[i]]);
		end
	end

endmodule

/* include/tankGame_macros.svh */
`ifndef TANKGAME_MACROS_SVH
`define TANKGAME_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Raster and colour widths
//////////////////////////////////////////////////////////////////////

// Bits of a pixel coordinate
`define COORD_WIDTH 10
// Bits per colour channel
`define COLOUR_WIDTH 4
// Bits of a tile code
`define CODE_WIDTH 4

//////////////////////////////////////////////////////////////////////
// Screen and tile geometry
//////////////////////////////////////////////////////////////////////

// Tiles are 32 pixels square
`define TILE_SHIFT 5
`define MAP_COLS 20
`define MAP_ROWS 15
// Tile index widths for 20 columns and 15 rows
`define COL_WIDTH 5
`define ROW_WIDTH 4
// Last visible column and row
`define SCREEN_WIDTH 640
`define SCREEN_HEIGHT 480

//////////////////////////////////////////////////////////////////////
// Tank and score
//////////////////////////////////////////////////////////////////////

// Box spans position to position plus this, inclusive
`define TANK_WIDTH 25
`define TANK_START 5
`define COIN_WIDTH 8

`endif
